/* src/bp_pkg.sv */
package bp_pkg;

    // sinogram sample width, unsigned
    localparam int DATA_W = 12;

    // filtered sample, signed
    // gain of the 2/-1/-1 kernel stays within 4x full scale
    localparam int FILT_W = 15;

    // pixel accumulator, signed
    localparam int ACC_W = 22;

    // angle index, table covers 8 angles in 22.5 degree steps
    localparam int ANGLE_W = 3;

    // trig values scaled by 2**TRIG_FRAC
    localparam int TRIG_FRAC = 6;
    localparam int TRIG_W = 8;

    // cos(k * 22.5 deg) * 64, rounded
    localparam logic signed [TRIG_W-1:0] COS_TABLE [0:7] = '{
        8'sd64,
        8'sd59,
        8'sd45,
        8'sd24,
        8'sd0,
        -8'sd24,
        -8'sd45,
        -8'sd59
    };

    // sin(k * 22.5 deg) * 64, rounded
    localparam logic signed [TRIG_W-1:0] SIN_TABLE [0:7] = '{
        8'sd0,
        8'sd24,
        8'sd45,
        8'sd59,
        8'sd64,
        8'sd59,
        8'sd45,
        8'sd24
    };

    // job phases
    // idle until start, load one line, project it, read image out, wait for start drop
    localparam logic [2:0] PH_IDLE = 3'd0;
    localparam logic [2:0] PH_LOAD = 3'd1;
    localparam logic [2:0] PH_PROJECT = 3'd2;
    localparam logic [2:0] PH_READOUT = 3'd3;
    localparam logic [2:0] PH_DONE = 3'd4;

endpackage

/* src/bp_angle_sequencer.sv */
module bp_angle_sequencer #(
    parameter int NO_OF_PES = 8,
    parameter int S_COUNT = 16,
    parameter int NO_OF_ANGLES = 8
) (
    input logic clk,
    input logic rst,
    // host handshake
    input logic start_req,
    output logic start_ack,
    // sinogram RAM
    output logic sg_rd,
    output logic [$clog2(NO_OF_ANGLES*S_COUNT)-1:0] sg_addr,
    // to filter
    output logic smp_valid,
    output logic smp_first,
    output logic line_end,
    // to processing elements
    output logic proj_en,
    output logic [$clog2(NO_OF_PES)-1:0] col_x,
    output logic signed [bp_pkg::TRIG_W-1:0] cos_val,
    output logic signed [bp_pkg::TRIG_W-1:0] sin_val,
    output logic clear_acc,
    // to and from readout
    output logic rd_start,
    input logic rd_done
);

    localparam int SG_ADDR_W = $clog2(NO_OF_ANGLES*S_COUNT);
    localparam int COL_W = $clog2(NO_OF_PES);
    // sample counter also runs over the return and flush cycles
    localparam int S_CNT_W = $clog2(S_COUNT+2);
    // column counter includes the idle cycle after the last column
    localparam int COL_CNT_W = $clog2(NO_OF_PES+1);

    logic [2:0] phase;
    logic [bp_pkg::ANGLE_W-1:0] angle;
    logic [S_CNT_W-1:0] s_cnt;
    logic [COL_CNT_W-1:0] col_cnt;
    logic last_angle;

    assign last_angle = (angle == bp_pkg::ANGLE_W'(NO_OF_ANGLES-1));

    // read cycles are the first S_COUNT cycles of a load
    assign sg_rd = (phase == bp_pkg::PH_LOAD) && (s_cnt < S_CNT_W'(S_COUNT));
    // row-major sinogram, one line of S_COUNT samples per angle
    assign sg_addr = SG_ADDR_W'(angle * S_COUNT) + SG_ADDR_W'(s_cnt);

    assign proj_en = (phase == bp_pkg::PH_PROJECT) && (col_cnt < COL_CNT_W'(NO_OF_PES));
    assign col_x = col_cnt[COL_W-1:0];

    // geometry of the current angle
    assign cos_val = bp_pkg::COS_TABLE[angle];
    assign sin_val = bp_pkg::SIN_TABLE[angle];

    assign start_ack = (phase == bp_pkg::PH_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= bp_pkg::PH_IDLE;
            angle <= '0;
            s_cnt <= '0;
            col_cnt <= '0;
            smp_valid <= 1'b0;
            smp_first <= 1'b0;
            line_end <= 1'b0;
            clear_acc <= 1'b0;
            rd_start <= 1'b0;
        end else begin
            // RAM data comes back one cycle after the read
            smp_valid <= sg_rd;
            smp_first <= sg_rd && (s_cnt == '0);
            // flush pulse right after the last sample
            line_end <= (phase == bp_pkg::PH_LOAD) && (s_cnt == S_CNT_W'(S_COUNT));
            clear_acc <= 1'b0;
            rd_start <= 1'b0;
            case (phase)
                bp_pkg::PH_IDLE: begin
                    if (start_req) begin
                        phase <= bp_pkg::PH_LOAD;
                        angle <= '0;
                        s_cnt <= '0;
                        clear_acc <= 1'b1;
                    end
                end
                bp_pkg::PH_LOAD: begin
                    if (s_cnt == S_CNT_W'(S_COUNT+1)) begin
                        phase <= bp_pkg::PH_PROJECT;
                        col_cnt <= '0;
                    end else begin
                        s_cnt <= s_cnt + 1'b1;
                    end
                end
                bp_pkg::PH_PROJECT: begin
                    // last count is the idle cycle that lets the final add land
                    if (col_cnt == COL_CNT_W'(NO_OF_PES)) begin
                        if (last_angle) begin
                            phase <= bp_pkg::PH_READOUT;
                            rd_start <= 1'b1;
                        end else begin
                            phase <= bp_pkg::PH_LOAD;
                            angle <= angle + 1'b1;
                            s_cnt <= '0;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                bp_pkg::PH_READOUT: begin
                    if (rd_done) begin
                        phase <= bp_pkg::PH_DONE;
                    end
                end
                bp_pkg::PH_DONE: begin
                    // ack held until the host drops its request
                    if (!start_req) begin
                        phase <= bp_pkg::PH_IDLE;
                    end
                end
                default: begin
                    phase <= bp_pkg::PH_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/bp_filter.sv */
module bp_filter #(
    parameter int S_COUNT = 16
) (
    input logic clk,
    input logic rst,
    input logic [bp_pkg::DATA_W-1:0] sg_val,
    input logic smp_valid,
    input logic smp_first,
    input logic line_end,
    output logic [S_COUNT*bp_pkg::FILT_W-1:0] line_buf
);

    localparam int FILT_W = bp_pkg::FILT_W;
    localparam int IDX_W = $clog2(S_COUNT);

    // sample history, v_cur is the sample being filtered
    logic [bp_pkg::DATA_W-1:0] v_cur;
    logic [bp_pkg::DATA_W-1:0] v_prev;
    logic [IDX_W-1:0] wr_idx;
    logic signed [FILT_W-1:0] buf_q [S_COUNT];

    logic signed [FILT_W-1:0] cur_ext;
    logic signed [FILT_W-1:0] prev_ext;
    logic signed [FILT_W-1:0] next_ext;
    logic signed [FILT_W-1:0] filt;
    logic wr_en;

    // zero extend the unsigned samples
    assign cur_ext = $signed(FILT_W'(v_cur));
    assign prev_ext = $signed(FILT_W'(v_prev));
    // right neighbour missing on the flush cycle
    assign next_ext = smp_valid ? $signed(FILT_W'(sg_val)) : '0;

    // 2*v[s] - v[s-1] - v[s+1]
    assign filt = (cur_ext <<< 1) - prev_ext - next_ext;

    // sample s is done once s+1 shows up, the last one on line_end
    assign wr_en = (smp_valid && !smp_first) || line_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx <= '0;
        end else if (smp_valid && smp_first) begin
            wr_idx <= '0;
        end else if (smp_valid) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (smp_valid) begin
            // new line starts with an empty left neighbour
            v_prev <= smp_first ? '0 : v_cur;
            v_cur <= sg_val;
        end
        if (wr_en) begin
            buf_q[wr_idx] <= filt;
        end
    end

    // flatten for the PE row
    always_comb begin
        for (int i = 0; i < S_COUNT; i++) begin
            line_buf[i*FILT_W +: FILT_W] = buf_q[i];
        end
    end

endmodule

/* src/bp_processing_element.sv */
module bp_processing_element #(
    parameter int NO_OF_PES = 8,
    parameter int S_COUNT = 16,
    parameter int ROW = 0
) (
    input logic clk,
    input logic rst,
    input logic clear_acc,
    input logic proj_en,
    input logic [$clog2(NO_OF_PES)-1:0] col_x,
    input logic signed [bp_pkg::TRIG_W-1:0] cos_val,
    input logic signed [bp_pkg::TRIG_W-1:0] sin_val,
    input logic [S_COUNT*bp_pkg::FILT_W-1:0] line_buf,
    input logic [$clog2(NO_OF_PES)-1:0] rd_x,
    output logic signed [bp_pkg::ACC_W-1:0] row_val
);

    localparam int COL_W = $clog2(NO_OF_PES);
    localparam int IDX_W = $clog2(S_COUNT);
    localparam int FILT_W = bp_pkg::FILT_W;
    localparam int ACC_W = bp_pkg::ACC_W;
    // offsets are COL_W+2 bits signed
    localparam int OFS_W = COL_W + 2;
    localparam int SUM_W = OFS_W + bp_pkg::TRIG_W + 2;
    // row offset from image centre, fixed per element
    localparam logic signed [OFS_W-1:0] DY = OFS_W'(ROW - NO_OF_PES/2);

    logic signed [OFS_W-1:0] dx;
    logic signed [SUM_W-1:0] proj;
    logic signed [SUM_W-1:0] s_full;
    logic in_range;

    // stage 1 result
    logic [IDX_W-1:0] idx_q;
    logic [COL_W-1:0] col_q;
    logic hit_q;

    logic signed [FILT_W-1:0] smp;
    logic signed [ACC_W-1:0] acc [NO_OF_PES];

    // column offset from image centre
    assign dx = $signed({2'b00, col_x}) - OFS_W'(NO_OF_PES/2);

    // t = dx*cos + dy*sin, scaled by 2**TRIG_FRAC
    assign proj = SUM_W'(dx) * SUM_W'(cos_val) + SUM_W'(DY) * SUM_W'(sin_val);

    // floor shift, then centre on the detector
    assign s_full = (proj >>> bp_pkg::TRIG_FRAC) + SUM_W'(S_COUNT/2);

    // rays that miss the detector add nothing
    assign in_range = !s_full[SUM_W-1] && (s_full < SUM_W'(S_COUNT));

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= proj_en && in_range;
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= s_full[IDX_W-1:0];
        col_q <= col_x;
    end

    // stage 2, pick the filtered sample
    assign smp = $signed(line_buf[idx_q*FILT_W +: FILT_W]);

    always_ff @(posedge clk) begin
        if (clear_acc) begin
            for (int i = 0; i < NO_OF_PES; i++) begin
                acc[i] <= '0;
            end
        end else if (hit_q) begin
            acc[col_q] <= acc[col_q] + ACC_W'(smp);
        end
    end

    // readout port, one pixel of this row
    assign row_val = acc[rd_x];

endmodule

/* src/bp_image_readout.sv */
module bp_image_readout #(
    parameter int NO_OF_PES = 8
) (
    input logic clk,
    input logic rst,
    input logic rd_start,
    input logic [NO_OF_PES*bp_pkg::ACC_W-1:0] rows_flat,
    input logic ir_ack,
    output logic [$clog2(NO_OF_PES)-1:0] rd_x,
    output logic rd_done,
    // image RAM four-phase handshake
    output logic ir_req,
    output logic [$clog2(NO_OF_PES*NO_OF_PES)-1:0] ir_addr,
    output logic signed [bp_pkg::ACC_W-1:0] ir_val
);

    localparam int ACC_W = bp_pkg::ACC_W;
    localparam int COL_W = $clog2(NO_OF_PES);
    localparam int ADDR_W = $clog2(NO_OF_PES*NO_OF_PES);

    logic [2:0] phase;
    logic [COL_W-1:0] x_cnt;
    logic [COL_W-1:0] y_cnt;
    // ack seen, waiting for it to go low
    logic wait_low;
    logic last_x;
    logic last_pix;
    logic [ACC_W-1:0] sel_val;

    assign last_x = (x_cnt == COL_W'(NO_OF_PES-1));
    assign last_pix = last_x && (y_cnt == COL_W'(NO_OF_PES-1));

    // PEs return the column asked for, this picks the row
    assign rd_x = x_cnt;
    assign sel_val = rows_flat[y_cnt*ACC_W +: ACC_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= bp_pkg::PH_IDLE;
            x_cnt <= '0;
            y_cnt <= '0;
            ir_req <= 1'b0;
            wait_low <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (phase)
                bp_pkg::PH_IDLE: begin
                    if (rd_start) begin
                        phase <= bp_pkg::PH_READOUT;
                        x_cnt <= '0;
                        y_cnt <= '0;
                    end
                end
                bp_pkg::PH_READOUT: begin
                    if (!ir_req && !wait_low) begin
                        // present pixel, registered so it holds while stalled
                        ir_req <= 1'b1;
                        ir_addr <= ADDR_W'(y_cnt * NO_OF_PES) + ADDR_W'(x_cnt);
                        ir_val <= $signed(sel_val);
                    end else if (ir_req && ir_ack) begin
                        ir_req <= 1'b0;
                        wait_low <= 1'b1;
                    end else if (wait_low && !ir_ack) begin
                        wait_low <= 1'b0;
                        if (last_pix) begin
                            phase <= bp_pkg::PH_IDLE;
                            rd_done <= 1'b1;
                        end else if (last_x) begin
                            x_cnt <= '0;
                            y_cnt <= y_cnt + 1'b1;
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    phase <= bp_pkg::PH_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/bp_top.sv */
module bp_top #(
    parameter int NO_OF_PES = 8,
    parameter int S_COUNT = 16,
    parameter int NO_OF_ANGLES = 8
) (
    input logic clk,
    input logic rst,
    // host
    input logic start_req,
    output logic start_ack,
    // sinogram RAM
    input logic [bp_pkg::DATA_W-1:0] sg_val,
    output logic sg_rd,
    output logic [$clog2(NO_OF_ANGLES*S_COUNT)-1:0] sg_addr,
    // image RAM
    input logic ir_ack,
    output logic ir_req,
    output logic [$clog2(NO_OF_PES*NO_OF_PES)-1:0] ir_addr,
    output logic signed [bp_pkg::ACC_W-1:0] ir_val
);

    localparam int COL_W = $clog2(NO_OF_PES);
    localparam int ACC_W = bp_pkg::ACC_W;

    // sequencer to filter
    logic smp_valid;
    logic smp_first;
    logic line_end;
    logic [S_COUNT*bp_pkg::FILT_W-1:0] line_buf;

    // sequencer broadcast to the PE row
    logic proj_en;
    logic [COL_W-1:0] col_x;
    logic signed [bp_pkg::TRIG_W-1:0] cos_val;
    logic signed [bp_pkg::TRIG_W-1:0] sin_val;
    logic clear_acc;

    // readout side
    logic rd_start;
    logic rd_done;
    logic [COL_W-1:0] rd_x;
    logic [NO_OF_PES*ACC_W-1:0] rows_flat;

    // decode, job and angle stepping
    bp_angle_sequencer #(
        .NO_OF_PES(NO_OF_PES),
        .S_COUNT(S_COUNT),
        .NO_OF_ANGLES(NO_OF_ANGLES)
    ) i_sequencer (
        .clk(clk),
        .rst(rst),
        .start_req(start_req),
        .start_ack(start_ack),
        .sg_rd(sg_rd),
        .sg_addr(sg_addr),
        .smp_valid(smp_valid),
        .smp_first(smp_first),
        .line_end(line_end),
        .proj_en(proj_en),
        .col_x(col_x),
        .cos_val(cos_val),
        .sin_val(sin_val),
        .clear_acc(clear_acc),
        .rd_start(rd_start),
        .rd_done(rd_done)
    );

    // ramp filter into the line buffer
    bp_filter #(
        .S_COUNT(S_COUNT)
    ) i_filter (
        .clk(clk),
        .rst(rst),
        .sg_val(sg_val),
        .smp_valid(smp_valid),
        .smp_first(smp_first),
        .line_end(line_end),
        .line_buf(line_buf)
    );

    // execute, one element per image row
    for (genvar r = 0; r < NO_OF_PES; r++) begin : g_pe
        bp_processing_element #(
            .NO_OF_PES(NO_OF_PES),
            .S_COUNT(S_COUNT),
            .ROW(r)
        ) i_pe (
            .clk(clk),
            .rst(rst),
            .clear_acc(clear_acc),
            .proj_en(proj_en),
            .col_x(col_x),
            .cos_val(cos_val),
            .sin_val(sin_val),
            .line_buf(line_buf),
            .rd_x(rd_x),
            .row_val(rows_flat[r*ACC_W +: ACC_W])
        );
    end

    // result, pixels out to the image RAM
    bp_image_readout #(
        .NO_OF_PES(NO_OF_PES)
    ) i_readout (
        .clk(clk),
        .rst(rst),
        .rd_start(rd_start),
        .rows_flat(rows_flat),
        .ir_ack(ir_ack),
        .rd_x(rd_x),
        .rd_done(rd_done),
        .ir_req(ir_req),
        .ir_addr(ir_addr),
        .ir_val(ir_val)
    );

endmodule

/* verif/bp_top_sva.sv */
module bp_top_sva #(
    parameter int NO_OF_PES = 8
) (
    input logic clk,
    input logic rst,
    input logic start_req,
    input logic start_ack,
    input logic sg_rd,
    input logic ir_req,
    input logic ir_ack,
    input logic [$clog2(NO_OF_PES*NO_OF_PES)-1:0] ir_addr,
    input logic signed [bp_pkg::ACC_W-1:0] ir_val
);
    timeunit 1ns;
    timeprecision 100ps;

    // outputs quiet once reset is released
    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !start_ack && !sg_rd && !ir_req)
        else $error("start_ack, sg_rd or ir_req high after reset");

    // request drops only after the image RAM acknowledged it
    a_req_fall: assert property (@(posedge clk) disable iff (rst) $fell(ir_req) |-> $past(ir_ack))
        else $error("ir_req dropped without ir_ack");

    // next pixel only once ack is back low
    a_req_rise: assert property (@(posedge clk) disable iff (rst) $rose(ir_req) |-> !ir_ack)
        else $error("ir_req raised while ir_ack still high");

    // address and data frozen during a stalled request
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        ir_req && $past(ir_req) |-> $stable(ir_addr) && $stable(ir_val))
        else $error("ir_addr or ir_val changed while ir_req high");

    // ack only answers a pending host request
    a_ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(start_ack) |-> start_req)
        else $error("start_ack rose without start_req");

endmodule

bind bp_top bp_top_sva #(
    .NO_OF_PES(NO_OF_PES)
) i_sva (
    .clk(clk),
    .rst(rst),
    .start_req(start_req),
    .start_ack(start_ack),
    .sg_rd(sg_rd),
    .ir_req(ir_req),
    .ir_ack(ir_ack),
    .ir_addr(ir_addr),
    .ir_val(ir_val)
);

/* verif/bp_tb.sv */
module bp_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NO_OF_PES = 8;
    localparam int S_COUNT = 16;
    localparam int NO_OF_ANGLES = 8;
    localparam int PIX = NO_OF_PES * NO_OF_PES;
    localparam int SG_DEPTH = NO_OF_ANGLES * S_COUNT;
    localparam int SG_ADDR_W = $clog2(SG_DEPTH);
    localparam int IR_ADDR_W = $clog2(PIX);
    localparam int DATA_W = bp_pkg::DATA_W;
    localparam int ACC_W = bp_pkg::ACC_W;
    localparam int TIMEOUT_CYCLES = 1000;

    // sinogram pattern kinds
    localparam int KIND_ZERO = 0;
    localparam int KIND_CONST = 1;
    localparam int KIND_IMPULSE = 2;
    localparam int KIND_RANDOM = 3;
    localparam int NO_OF_JOBS = 7;

    logic clk = 1'b0;
    logic rst;
    logic start_req;
    logic start_ack;
    logic [DATA_W-1:0] sg_val = '0;
    logic sg_rd;
    logic [SG_ADDR_W-1:0] sg_addr;
    logic ir_ack = 1'b0;
    logic ir_req;
    logic [IR_ADDR_W-1:0] ir_addr;
    logic signed [ACC_W-1:0] ir_val;

    logic [DATA_W-1:0] sino [SG_DEPTH];
    int ref_img [PIX];
    logic fast_ack = 1'b1;
    int ack_cnt = 0;
    int ack_target = 0;

    // kind, angle, sample, amplitude, fast ack
    int job_tab [NO_OF_JOBS][5] = '{
        '{KIND_ZERO, 0, 0, 0, 1},
        '{KIND_IMPULSE, 0, 8, 100, 1},
        '{KIND_IMPULSE, 3, 2, 4095, 0},
        '{KIND_IMPULSE, 6, 13, 1000, 0},
        '{KIND_CONST, 0, 0, 2000, 0},
        '{KIND_RANDOM, 0, 0, 0, 0},
        '{KIND_RANDOM, 0, 0, 0, 1}
    };

    bp_top #(
        .NO_OF_PES(NO_OF_PES),
        .S_COUNT(S_COUNT),
        .NO_OF_ANGLES(NO_OF_ANGLES)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .start_req(start_req),
        .start_ack(start_ack),
        .sg_val(sg_val),
        .sg_rd(sg_rd),
        .sg_addr(sg_addr),
        .ir_ack(ir_ack),
        .ir_req(ir_req),
        .ir_addr(ir_addr),
        .ir_val(ir_val)
    );

    always #2 clk = ~clk;

    // sinogram RAM, data one cycle after the read
    always @(posedge clk) begin
        if (sg_rd) begin
            sg_val <= sino[sg_addr];
        end
    end

    // image RAM ack, follows ir_req after 0 to 5 cycles
    always @(posedge clk) begin
        if (rst) begin
            ir_ack <= 1'b0;
            ack_cnt <= 0;
            ack_target <= 0;
        end else if (ir_req !== ir_ack) begin
            if (ack_cnt >= ack_target) begin
                ir_ack <= ir_req;
                ack_cnt <= 0;
                ack_target <= fast_ack ? 0 : int'($urandom_range(5, 0));
            end else begin
                ack_cnt <= ack_cnt + 1;
            end
        end
    end

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        stop_on_error();
    endtask

    task automatic check_addr(input string name, input logic [IR_ADDR_W-1:0] got,
                              input logic [IR_ADDR_W-1:0] want);
        if (got !== want) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, want, got);
            stop_on_error();
        end
    endtask

    task automatic check_pixel(input string name, input logic signed [ACC_W-1:0] got,
                               input logic signed [ACC_W-1:0] want);
        if (got !== want) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, want, got);
            stop_on_error();
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, want, got);
            stop_on_error();
        end
    endtask

    task automatic fill_sinogram(input int kind, input int ang, input int smp, input int amp);
        for (int i = 0; i < SG_DEPTH; i++) begin
            case (kind)
                KIND_CONST: sino[i] = DATA_W'(amp);
                KIND_IMPULSE: sino[i] = (i == ang * S_COUNT + smp) ? DATA_W'(amp) : '0;
                KIND_RANDOM: sino[i] = DATA_W'($urandom_range(4095, 0));
                default: sino[i] = '0;
            endcase
        end
    endtask

    // ramp filter with zero edges, then nearest-below backprojection
    task automatic build_reference();
        int filt [S_COUNT];
        int v_l;
        int v_r;
        int base;
        int t;
        int s;
        int c;
        c = NO_OF_PES / 2;
        for (int p = 0; p < PIX; p++) begin
            ref_img[p] = 0;
        end
        for (int a = 0; a < NO_OF_ANGLES; a++) begin
            base = a * S_COUNT;
            for (int k = 0; k < S_COUNT; k++) begin
                v_l = (k == 0) ? 0 : int'(sino[base + k - 1]);
                v_r = (k == S_COUNT - 1) ? 0 : int'(sino[base + k + 1]);
                filt[k] = 2 * int'(sino[base + k]) - v_l - v_r;
            end
            for (int y = 0; y < NO_OF_PES; y++) begin
                for (int x = 0; x < NO_OF_PES; x++) begin
                    t = (x - c) * int'(bp_pkg::COS_TABLE[a])
                        + (y - c) * int'(bp_pkg::SIN_TABLE[a]);
                    // floor division by the trig scale
                    s = (t >>> bp_pkg::TRIG_FRAC) + S_COUNT / 2;
                    if (s >= 0 && s < S_COUNT) begin
                        ref_img[y * NO_OF_PES + x] += filt[s];
                    end
                end
            end
        end
    endtask

    task automatic wait_start_ack(input logic level);
        int n;
        n = 0;
        while (start_ack !== level) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                report_timeout("start_ack never reached the expected level");
            end
        end
    endtask

    // one pixel per handshake, addresses in order
    task automatic collect_image();
        int n;
        logic [IR_ADDR_W-1:0] want_addr;
        logic signed [ACC_W-1:0] want_val;
        for (int p = 0; p < PIX; p++) begin
            want_addr = IR_ADDR_W'(p);
            want_val = ACC_W'(ref_img[p]);
            n = 0;
            while (ir_req !== 1'b1) begin
                @(posedge clk);
                n++;
                if (n > TIMEOUT_CYCLES) begin
                    report_timeout("no image RAM request for the next pixel");
                end
            end
            verify_flag("start_ack", start_ack, 1'b0);
            check_addr("ir_addr", ir_addr, want_addr);
            check_pixel("ir_val", ir_val, want_val);
            // values must hold until the request is dropped
            n = 0;
            while (ir_req === 1'b1) begin
                @(posedge clk);
                n++;
                if (n > TIMEOUT_CYCLES) begin
                    report_timeout("ir_req stayed high after ir_ack");
                end
                if (ir_req === 1'b1) begin
                    check_addr("ir_addr", ir_addr, want_addr);
                    check_pixel("ir_val", ir_val, want_val);
                end
            end
        end
    endtask

    task automatic run_job(input int j);
        fill_sinogram(job_tab[j][0], job_tab[j][1], job_tab[j][2], job_tab[j][3]);
        build_reference();
        fast_ack = (job_tab[j][4] != 0);
        start_req <= 1'b1;
        collect_image();
        wait_start_ack(1'b1);
        start_req <= 1'b0;
        wait_start_ack(1'b0);
    endtask

    initial begin
        void'($urandom(6));
        rst = 1'b1;
        start_req = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // idle outputs straight after reset
        verify_flag("start_ack", start_ack, 1'b0);
        verify_flag("sg_rd", sg_rd, 1'b0);
        verify_flag("ir_req", ir_req, 1'b0);
        // jobs back to back, each must see cleared accumulators
        for (int j = 0; j < NO_OF_JOBS; j++) begin
            run_job(j);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* files.f */
src/bp_pkg.sv
src/bp_angle_sequencer.sv
src/bp_filter.sv
src/bp_processing_element.sv
src/bp_image_readout.sv
src/bp_top.sv
verif/bp_top_sva.sv
verif/bp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := bp_tb
FILELIST := files.f
BUILD_DIR := obj_dir
LOG := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -j 0
FAIL_MSG := Checks failed
PASS_MSG := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
